// File: laser_link.f
+incdir+bench
src/laser_link_pkg.sv
src/laser_serializer.sv
src/laser_deserializer.sv
src/tx_byte_queue.sv
src/marker_detector.sv
src/link_controller.sv
src/laser_link.sv
bench/laser_link_tb.sv

// File: bench/link_peer.svh
`ifndef LINK_PEER_SVH
`define LINK_PEER_SVH

    // peer frame on laser_rx, start bit low, data lsb first, stop bit high
    task automatic send_peer_byte(input byte_t value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clock);
            laser_rx <= frame[i];
            repeat (BIT_CLOCKS - 1) @(posedge clock);
        end
    endtask

    // returns at the middle of the stop bit
    task automatic catch_dut_byte(output byte_t value);
        int waited;
        waited = 0;
        value  = '0;
        @(posedge clock);
        while (laser_tx !== 1'b0) begin
            if (waited == WAIT_LIMIT) begin
                stop_with_failure("no start bit appeared on laser_tx");
            end
            waited++;
            @(posedge clock);
        end
        // half a bit to the middle of the start bit
        repeat (BIT_CLOCKS / 2) @(posedge clock);
        check_bit("laser_tx start bit", laser_tx, 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLOCKS) @(posedge clock);
            value[i] = laser_tx;
        end
        repeat (BIT_CLOCKS) @(posedge clock);
        check_bit("laser_tx stop bit", laser_tx, 1'b1);
    endtask

`endif

// File: bench/laser_link_tb.sv
`timescale 1ns/1ps

module laser_link_tb;
    import laser_link_pkg::*;

    typedef enum logic [1:0] {OP_FRAME, OP_HS_FRAME, OP_BURST} op_t;

    // mask bit i refuses payload byte i
    typedef struct packed {
        op_t          op;
        marker_kind_t kind;
        int           payload_len;
        logic [31:0]  refuse_mask;
        int           burst_len;
    } row_t;

    localparam int ROW_COUNT  = 7;
    localparam int WAIT_LIMIT = 4000;

    // 1023 payload bytes overrun the frame by three
    localparam row_t STIM_TABLE [ROW_COUNT] = '{
        '{OP_FRAME,    KIND_START, 6,    32'h0,   0},
        '{OP_FRAME,    KIND_DATA,  1023, 32'h0,   0},
        '{OP_HS_FRAME, KIND_STOP,  5,    32'h0,   0},
        '{OP_BURST,    KIND_START, 0,    32'h0,   5},
        '{OP_FRAME,    KIND_DATA,  12,   32'hA45, 0},
        '{OP_BURST,    KIND_START, 0,    32'h0,   16},
        '{OP_HS_FRAME, KIND_START, 9,    32'h181, 0}
    };

    logic   clock;
    logic   reset;
    logic   laser_rx;
    logic   laser_tx;
    byte_t  send_data;
    logic   send_write;
    logic   send_full;
    byte_t  recv_data;
    logic   recv_valid;
    logic   recv_full;
    integer seed = 32'h441b;
    int     hs_seen;
    byte_t  recv_log [$];
    byte_t  expected [$];

    laser_link dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // host side of the receive port
    always @(posedge clock) begin
        if (recv_valid === 1'b1) recv_log.push_back(recv_data);
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t want);
        if (got !== want) begin
            stop_with_failure($sformatf("Mismatch %s: got %h expected %h", name, got, want));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            stop_with_failure($sformatf("Mismatch %s: got %h expected %h", name, got, want));
        end
    endtask

    `include "link_peer.svh"

    // no request byte and no marker first byte
    function automatic byte_t random_payload();
        byte_t value;
        do begin
            value = byte_t'($random(seed));
        end while (value inside {HS_REQUEST, MARKER_START[31:24], MARKER_DATA[31:24],
                                 MARKER_STOP[31:24]});
        return value;
    endfunction

    // most significant byte goes out first
    function automatic byte_t marker_byte(input marker_kind_t kind, input int index);
        logic [31:0] word;
        case (kind)
            KIND_DATA: word = MARKER_DATA;
            KIND_STOP: word = MARKER_STOP;
            default:   word = MARKER_START;
        endcase
        return word[31 - 8 * index -: 8];
    endfunction

    task automatic send_frame(input row_t row);
        byte_t value;
        logic  refuse;
        for (int i = 0; i < 4; i++) begin
            expected.push_back(marker_byte(row.kind, i));
            send_peer_byte(marker_byte(row.kind, i));
        end
        // let the marker bytes drain before any refusal
        repeat (2 * BIT_CLOCKS) @(posedge clock);
        for (int i = 0; i < row.payload_len; i++) begin
            value  = random_payload();
            refuse = (i < 32) ? row.refuse_mask[i] : 1'b0;
            recv_full <= refuse;
            if (i < FRAME_BYTES - 4 && !refuse) expected.push_back(value);
            send_peer_byte(value);
        end
        recv_full <= 1'b0;
    endtask

    task automatic run_receive(input row_t row);
        byte_t reply;
        int    waited;
        expected.delete();
        recv_log.delete();
        if (row.op == OP_HS_FRAME) begin
            fork
                begin
                    send_peer_byte(HS_REQUEST);
                    send_peer_byte(HS_REQUEST);
                    send_frame(row);
                end
                begin
                    catch_dut_byte(reply);
                    check_byte("laser_tx reply", reply, HS_REPLY);
                end
            join
        end else begin
            send_frame(row);
        end
        waited = 0;
        while (recv_log.size() < expected.size()) begin
            if (waited == WAIT_LIMIT) stop_with_failure("recv_valid delivered too few bytes");
            waited++;
            @(posedge clock);
        end
        // the frame closes on silence, nothing more may arrive
        repeat (SILENCE_CLOCKS + 2 * BIT_CLOCKS) @(posedge clock);
        if (recv_log.size() != expected.size()) begin
            stop_with_failure($sformatf("Mismatch recv_valid count: got %h expected %h",
                                        recv_log.size(), expected.size()));
        end
        foreach (expected[i]) check_byte("recv_data", recv_log[i], expected[i]);
    endtask

    task automatic run_burst(input row_t row);
        byte_t sent [$];
        byte_t value;
        int    got;
        int    waited;
        hs_seen = 0;
        got     = 0;
        waited  = 0;
        for (int i = 0; i < row.burst_len; i++) sent.push_back(random_payload());
        fork
            begin
                foreach (sent[i]) begin
                    @(posedge clock);
                    send_write <= 1'b1;
                    send_data  <= sent[i];
                end
                @(posedge clock);
                send_write <= 1'b0;
                @(posedge clock);
                check_bit("send_full", send_full, row.burst_len == TX_QUEUE_DEPTH);
            end
            // peer answers the first request it hears
            begin
                while (hs_seen == 0) begin
                    if (waited == WAIT_LIMIT) stop_with_failure("no handshake request was sent");
                    waited++;
                    @(posedge clock);
                end
                send_peer_byte(HS_REPLY);
            end
            begin
                while (got < row.burst_len) begin
                    catch_dut_byte(value);
                    if (got == 0 && value == HS_REQUEST) begin
                        hs_seen++;
                    end else begin
                        check_byte("laser_tx data", value, sent[got]);
                        got++;
                    end
                end
            end
        join
        if (hs_seen < 2) stop_with_failure("handshake request was not repeated");
        repeat (4 * BIT_CLOCKS) @(posedge clock);
    endtask

    initial begin
        reset      = 1'b1;
        laser_rx   = 1'b1;
        send_data  = '0;
        send_write = 1'b0;
        recv_full  = 1'b0;
        hs_seen    = 0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        check_bit("laser_tx", laser_tx, 1'b1);
        check_bit("recv_valid", recv_valid, 1'b0);
        check_bit("send_full", send_full, 1'b0);
        for (int r = 0; r < ROW_COUNT; r++) begin
            if (STIM_TABLE[r].op == OP_BURST) run_burst(STIM_TABLE[r]);
            else run_receive(STIM_TABLE[r]);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: src/laser_link.sv
`timescale 1ns/1ps

module laser_link (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  laser_rx,
    output logic                  laser_tx,
    input  laser_link_pkg::byte_t send_data,
    input  logic                  send_write,
    output logic                  send_full,
    output laser_link_pkg::byte_t recv_data,
    output logic                  recv_valid,
    input  logic                  recv_full
);
    import laser_link_pkg::*;

    byte_t        tx_byte;
    byte_t        rx_byte;
    byte_t        queue_head;
    marker_kind_t marker_kind;
    logic         tx_start;
    logic         tx_done;
    logic         rx_valid;
    logic         marker_hit;
    logic         queue_empty;
    logic         queue_pop;

    laser_serializer serializer_i (
        .clock, .reset, .tx_start, .tx_byte, .laser_tx, .tx_done
    );

    laser_deserializer deserializer_i (
        .clock, .reset, .laser_rx, .rx_byte, .rx_valid
    );

    tx_byte_queue queue_i (
        .clock, .reset, .send_data, .send_write, .pop(queue_pop),
        .head(queue_head), .empty(queue_empty), .send_full
    );

    marker_detector detector_i (
        .clock, .reset, .rx_byte, .rx_valid, .marker_hit, .marker_kind
    );

    link_controller controller_i (
        .clock, .reset, .rx_byte, .rx_valid, .marker_hit, .marker_kind,
        .queue_head, .queue_empty, .queue_pop, .tx_start, .tx_byte, .tx_done,
        .recv_data, .recv_valid, .recv_full
    );

endmodule

// File: src/link_controller.sv
`timescale 1ns/1ps

module link_controller (
    input  logic                         clock,
    input  logic                         reset,
    input  laser_link_pkg::byte_t        rx_byte,
    input  logic                         rx_valid,
    input  logic                         marker_hit,
    input  laser_link_pkg::marker_kind_t marker_kind,
    input  laser_link_pkg::byte_t        queue_head,
    input  logic                         queue_empty,
    output logic                         queue_pop,
    output logic                         tx_start,
    output laser_link_pkg::byte_t        tx_byte,
    input  logic                         tx_done,
    output laser_link_pkg::byte_t        recv_data,
    output logic                         recv_valid,
    input  logic                         recv_full
);
    import laser_link_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE, ST_HS_SEND, ST_HS_DRAIN, ST_ALIGN, ST_SEND, ST_SEND_WAIT,
        ST_HS_RECV, ST_MARK0, ST_MARK1, ST_MARK2, ST_MARK3, ST_RECV
    } state_t;

    state_t                   state;
    state_t                   state_next;
    logic [TIMER_W-1:0]       timer;
    logic [FRAME_COUNT_W-1:0] frame_count;
    marker_word_t             marker_saved;
    logic                     timer_clear;
    logic                     timer_inc;
    logic                     count_clear;
    logic                     count_inc;
    logic                     marker_load;
    logic                     marker_shift;
    logic                     saw_request;
    logic                     saw_reply;
    logic                     silence_done;
    logic                     align_done;
    logic                     frame_done;
    logic                     in_marker;

    assign saw_request  = rx_valid && (rx_byte == HS_REQUEST);
    assign saw_reply    = rx_valid && (rx_byte == HS_REPLY);
    assign silence_done = (timer == TIMER_W'(SILENCE_CLOCKS - 1));
    assign align_done   = (timer == TIMER_W'(ALIGN_CLOCKS - 1));
    assign frame_done   = (frame_count == FRAME_COUNT_W'(FRAME_BYTES));
    assign in_marker    = state inside {ST_MARK0, ST_MARK1, ST_MARK2, ST_MARK3};

    // marker bytes leave from the top of the saved word
    assign recv_data = in_marker ? marker_saved.bytes[0] : rx_byte;

    always_comb begin
        state_next   = state;
        timer_clear  = 1'b0;
        timer_inc    = 1'b0;
        count_clear  = 1'b0;
        count_inc    = 1'b0;
        marker_load  = 1'b0;
        marker_shift = 1'b0;
        queue_pop    = 1'b0;
        tx_start     = 1'b0;
        tx_byte      = HS_REQUEST;
        recv_valid   = 1'b0;

        case (state)
            ST_IDLE: begin
                timer_clear = 1'b1;
                if (!queue_empty) begin
                    state_next = ST_HS_SEND;
                end else if (saw_request) begin
                    state_next = ST_HS_RECV;
                end else if (marker_hit) begin
                    state_next  = ST_MARK0;
                    marker_load = 1'b1;
                    count_clear = 1'b1;
                end
            end
            // request repeats back to back until the peer answers
            ST_HS_SEND: begin
                tx_start = 1'b1;
                if (saw_reply) state_next = ST_HS_DRAIN;
            end
            ST_HS_DRAIN: begin
                timer_clear = 1'b1;
                if (tx_done) state_next = ST_ALIGN;
            end
            ST_ALIGN: begin
                timer_inc = 1'b1;
                if (align_done) state_next = ST_SEND;
            end
            ST_SEND: begin
                tx_start   = 1'b1;
                tx_byte    = queue_head;
                queue_pop  = 1'b1;
                state_next = ST_SEND_WAIT;
            end
            ST_SEND_WAIT: begin
                if (tx_done) state_next = queue_empty ? ST_IDLE : ST_SEND;
            end
            // a reply is dropped if the serializer is still busy
            ST_HS_RECV: begin
                tx_byte  = HS_REPLY;
                tx_start = saw_request;
                if (marker_hit) begin
                    state_next  = ST_MARK0;
                    marker_load = 1'b1;
                    count_clear = 1'b1;
                    timer_clear = 1'b1;
                end else if (rx_valid) begin
                    timer_clear = 1'b1;
                end else if (silence_done) begin
                    state_next = ST_IDLE;
                end else begin
                    timer_inc = 1'b1;
                end
            end
            ST_MARK0, ST_MARK1, ST_MARK2, ST_MARK3: begin
                if (!recv_full) begin
                    recv_valid   = 1'b1;
                    marker_shift = 1'b1;
                    count_inc    = 1'b1;
                    state_next   = (state == ST_MARK3) ? ST_RECV : state_t'(state + 4'd1);
                end
            end
            ST_RECV: begin
                if (frame_done || silence_done) begin
                    state_next = ST_IDLE;
                end else if (rx_valid) begin
                    // refused bytes still count toward the frame
                    count_inc   = 1'b1;
                    timer_clear = 1'b1;
                    recv_valid  = !recv_full;
                end else begin
                    timer_inc = 1'b1;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= ST_IDLE;
            timer       <= '0;
            frame_count <= '0;
        end else begin
            state <= state_next;
            if (timer_clear) timer <= '0;
            else if (timer_inc) timer <= timer + 1'b1;
            if (count_clear) frame_count <= '0;
            else if (count_inc) frame_count <= frame_count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (marker_load) marker_saved <= MARKER_TABLE[marker_kind];
        else if (marker_shift) marker_saved.word <= {marker_saved.word[23:0], 8'h00};
    end

    // host back-pressure is always honoured
    no_push_when_full_a: assert property (@(posedge clock) disable iff (reset)
        recv_full |-> !recv_valid);

endmodule

// File: src/marker_detector.sv
`timescale 1ns/1ps

module marker_detector (
    input  logic                         clock,
    input  logic                         reset,
    input  laser_link_pkg::byte_t        rx_byte,
    input  logic                         rx_valid,
    output logic                         marker_hit,
    output laser_link_pkg::marker_kind_t marker_kind
);
    import laser_link_pkg::*;

    logic         armed;
    marker_kind_t armed_kind;
    logic [1:0]   match_idx;
    logic         first_hit;
    marker_kind_t first_kind;
    byte_t        expected;
    logic         next_match;

    // which marker, if any, starts with this byte
    always_comb begin
        first_hit  = 1'b0;
        first_kind = KIND_START;
        for (int k = 0; k < MARKER_COUNT; k++) begin
            if (rx_byte == MARKER_TABLE[k].bytes[0]) begin
                first_hit  = 1'b1;
                first_kind = marker_kind_t'(k);
            end
        end
    end

    assign expected    = MARKER_TABLE[armed_kind].bytes[match_idx];
    assign next_match  = rx_valid && armed && (rx_byte == expected);
    assign marker_hit  = next_match && (match_idx == 2'd3);
    assign marker_kind = armed_kind;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            armed      <= 1'b0;
            armed_kind <= KIND_START;
            match_idx  <= 2'd0;
        end else if (rx_valid) begin
            if (!armed) begin
                if (first_hit) begin
                    armed      <= 1'b1;
                    armed_kind <= first_kind;
                    match_idx  <= 2'd1;
                end
            end else if (next_match && match_idx != 2'd3) begin
                match_idx <= match_idx + 2'd1;
            end else begin
                // a full match or a miss, the missing byte is not retried
                armed     <= 1'b0;
                match_idx <= 2'd0;
            end
        end
    end

    // armed exactly while a marker is partly matched
    armed_index_a: assert property (@(posedge clock) disable iff (reset)
        armed == (match_idx != 2'd0));

endmodule

// File: src/tx_byte_queue.sv
`timescale 1ns/1ps

module tx_byte_queue (
    input  logic                  clock,
    input  logic                  reset,
    input  laser_link_pkg::byte_t send_data,
    input  logic                  send_write,
    input  logic                  pop,
    output laser_link_pkg::byte_t head,
    output logic                  empty,
    output logic                  send_full
);
    import laser_link_pkg::*;

    byte_t                   mem [TX_QUEUE_DEPTH];
    logic [QUEUE_ADDR_W-1:0] wr_ptr;
    logic [QUEUE_ADDR_W-1:0] rd_ptr;
    logic [QUEUE_ADDR_W:0]   count;
    logic                    push_ok;
    logic                    pop_ok;

    assign push_ok   = send_write && !send_full;
    assign pop_ok    = pop && !empty;
    assign empty     = (count == '0);
    assign send_full = (count == (QUEUE_ADDR_W + 1)'(TX_QUEUE_DEPTH));
    assign head      = mem[rd_ptr];

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
            if (push_ok && !pop_ok) count <= count + 1'b1;
            else if (pop_ok && !push_ok) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (push_ok) mem[wr_ptr] <= send_data;
    end

    // host must watch send_full
    no_overflow_a: assert property (@(posedge clock) disable iff (reset)
        send_write |-> !send_full);
    // controller pops only a queued byte
    no_underflow_a: assert property (@(posedge clock) disable iff (reset) pop |-> !empty);

endmodule

// File: src/laser_deserializer.sv
`timescale 1ns/1ps

module laser_deserializer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  laser_rx,
    output laser_link_pkg::byte_t rx_byte,
    output logic                  rx_valid
);
    import laser_link_pkg::*;

    logic                   rx_meta;
    logic                   rx_sync;
    logic                   rx_prev;
    logic                   busy;
    logic [BIT_COUNT_W-1:0] bit_cnt;
    logic [BIT_INDEX_W-1:0] bit_idx;
    logic [BIT_COUNT_W-1:0] sample_at;
    logic                   sample;
    byte_t                  data_shift;

    // half a bit to the middle of the start bit, whole bits after that
    assign sample_at = (bit_idx == '0) ? BIT_COUNT_W'(BIT_CLOCKS / 2 - 1)
                                       : BIT_COUNT_W'(BIT_CLOCKS - 1);
    assign sample    = busy && (bit_cnt == sample_at);
    assign rx_byte   = data_shift;

    // synchronizer and edge history idle high like the line
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= laser_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!busy) begin
                if (rx_prev && !rx_sync) begin
                    busy    <= 1'b1;
                    bit_cnt <= '0;
                    bit_idx <= '0;
                end
            end else if (sample) begin
                bit_cnt <= '0;
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == '0 && rx_sync) begin
                    // glitch, start bit gone by mid-bit
                    busy <= 1'b0;
                end else if (bit_idx == BIT_INDEX_W'(FRAME_BITS - 1)) begin
                    busy     <= 1'b0;
                    rx_valid <= rx_sync;
                end
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (sample && bit_idx != '0 && bit_idx != BIT_INDEX_W'(FRAME_BITS - 1)) begin
            data_shift <= {rx_sync, data_shift[7:1]};
        end
    end

endmodule

// File: src/laser_serializer.sv
`timescale 1ns/1ps

module laser_serializer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  tx_start,
    input  laser_link_pkg::byte_t tx_byte,
    output logic                  laser_tx,
    output logic                  tx_done
);
    import laser_link_pkg::*;

    logic                   busy;
    logic [BIT_COUNT_W-1:0] bit_cnt;
    logic [BIT_INDEX_W-1:0] bit_idx;
    byte_t                  data_shift;

    // bit_idx 0 is the start bit, 1 to 8 data, last is the stop bit
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            laser_tx <= 1'b1;
            tx_done  <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (!busy) begin
                if (tx_start) begin
                    busy     <= 1'b1;
                    bit_cnt  <= '0;
                    bit_idx  <= '0;
                    laser_tx <= 1'b0;
                end
            end else if (bit_cnt == BIT_COUNT_W'(BIT_CLOCKS - 1)) begin
                bit_cnt <= '0;
                if (bit_idx == BIT_INDEX_W'(FRAME_BITS - 1)) begin
                    busy    <= 1'b0;
                    tx_done <= 1'b1;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                    // after the last data bit comes the stop bit
                    laser_tx <= (bit_idx == BIT_INDEX_W'(FRAME_BITS - 2)) ? 1'b1 : data_shift[0];
                end
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // lsb first
    always_ff @(posedge clock) begin
        if (!busy && tx_start) begin
            data_shift <= tx_byte;
        end else if (busy && bit_cnt == BIT_COUNT_W'(BIT_CLOCKS - 1)) begin
            data_shift <= data_shift >> 1;
        end
    end

    // line must rest high between frames
    idle_high_a: assert property (@(posedge clock) disable iff (reset) !busy |-> laser_tx);

endmodule

// File: src/laser_link_pkg.sv
package laser_link_pkg;

    typedef logic [7:0] byte_t;

    // order matches MARKER_TABLE
    typedef enum logic [1:0] {
        KIND_START = 2'd0,
        KIND_DATA  = 2'd1,
        KIND_STOP  = 2'd2
    } marker_kind_t;

    // marker word, bytes[0] is the first byte on the line
    typedef union packed {
        logic [31:0] word;
        byte_t [0:3] bytes;
    } marker_word_t;

    // serial line timing
    localparam int BIT_CLOCKS  = 16;
    localparam int FRAME_BITS  = 10;
    localparam int BIT_COUNT_W = $clog2(BIT_CLOCKS);
    localparam int BIT_INDEX_W = $clog2(FRAME_BITS);

    // handshake bytes
    localparam byte_t HS_REQUEST = 8'hAA;
    localparam byte_t HS_REPLY   = 8'h10;

    // first bytes must all differ, the detector arms on them
    localparam logic [31:0] MARKER_START = 32'hC1C2C3C4;
    localparam logic [31:0] MARKER_DATA  = 32'hD1D2D3D4;
    localparam logic [31:0] MARKER_STOP  = 32'h51525354;

    localparam int MARKER_COUNT = 3;
    localparam marker_word_t MARKER_TABLE [MARKER_COUNT] = '{
        MARKER_START,
        MARKER_DATA,
        MARKER_STOP
    };

    // frame and timeout lengths
    localparam int FRAME_BYTES    = 1024;
    localparam int SILENCE_CLOCKS = 1024;
    localparam int ALIGN_CLOCKS   = 192;
    // one timer serves both silence and alignment
    localparam int TIMER_W        = $clog2(SILENCE_CLOCKS) + 1;
    localparam int FRAME_COUNT_W  = $clog2(FRAME_BYTES) + 1;

    // transmit queue
    localparam int TX_QUEUE_DEPTH = 16;
    localparam int QUEUE_ADDR_W   = $clog2(TX_QUEUE_DEPTH);

endpackage
